//--- src/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// memory geometry
`define CPU_DATA_W 16  // one word, also the register width
`define CPU_ADDR_W 8   // 256 words

// register file
`define CPU_REG_COUNT 16

// words 0..63 hold data, the program starts right after
`define CPU_PROG_START 64

// trace line, short bit time so simulation stays quick
`define CPU_CLKS_PER_BIT 4

// opcode bytes waiting for the serializer
`define CPU_TRACE_DEPTH 4

`endif

//--- src/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] word_t;  // memory and register word
  typedef logic [`CPU_ADDR_W-1:0] addr_t;  // word address
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_idx_t;  // low nibble of word 1

  // high byte of the first instruction word
  typedef enum logic [7:0] {
    op_jmp     = 8'd1,   // word 2 is the target
    op_ram2reg = 8'd2,   // mem[word 2] -> reg
    op_reg2ram = 8'd3,   // reg -> mem[word 2]
    op_num2reg = 8'd4,   // word 2 -> reg
    op_halt    = 8'd15
  } opcode_t;

  typedef enum logic [2:0] {
    idle,
    read_first,   // word 1 from memory
    read_second,  // word 2 from memory
    offer,        // buffer full, waiting for the execute slot
    halted
  } fetch_state_t;

  typedef enum logic [1:0] {
    wait_instr,
    mem_access,  // load or store handshake
    push_trace,  // opcode byte into the trace fifo
    done
  } exec_state_t;

endpackage

//--- src/shared_ram.sv
`include "cpu_config.svh"

module shared_ram (
  input  logic           clk,
  input  logic           exec,
  input  logic           host_req,
  input  logic           host_we,
  input  cpu_pkg::addr_t host_addr,
  input  cpu_pkg::word_t host_wdata,
  output cpu_pkg::word_t host_rdata,
  output logic           host_ack,
  input  logic           fetch_req,
  input  cpu_pkg::addr_t fetch_addr,
  output cpu_pkg::word_t fetch_rdata,
  output logic           fetch_ack,
  input  logic           mem_req,
  input  logic           mem_we,
  input  cpu_pkg::addr_t mem_addr,
  input  cpu_pkg::word_t mem_wdata,
  output cpu_pkg::word_t mem_rdata,
  output logic           mem_ack
);
  import cpu_pkg::*;

  localparam int unsigned depth = 1 << `CPU_ADDR_W;
  localparam int host_i  = 0;  // bit positions in grant and ack, host wins first
  localparam int mem_i   = 1;
  localparam int fetch_i = 2;

  word_t      ram [depth];
  word_t      rdata_q;   // shared by all three, ack tells who owns it
  logic [2:0] req_vec;
  logic [2:0] pick;      // next winner
  logic [2:0] grant;     // one-hot, zero when free
  logic [2:0] ack_q;
  logic       access;    // granted, not yet served
  logic       sel_req;
  logic       sel_we;
  addr_t      sel_addr;
  word_t      sel_wdata;

  assign req_vec = {fetch_req, mem_req, host_req};
  assign access  = (grant != '0) && (ack_q == '0);
  assign sel_req = |(req_vec & grant);

  always_comb begin
    pick = '0;
    if (host_req) pick[host_i] = 1'b1;
    else if (mem_req) pick[mem_i] = 1'b1;
    else if (fetch_req) pick[fetch_i] = 1'b1;
  end

  // fetch only reads, so it is the fallback
  always_comb begin
    sel_we    = 1'b0;
    sel_addr  = fetch_addr;
    sel_wdata = mem_wdata;
    if (grant[host_i]) begin
      sel_we    = host_we;
      sel_addr  = host_addr;
      sel_wdata = host_wdata;
    end else if (grant[mem_i]) begin
      sel_we    = mem_we;
      sel_addr  = mem_addr;
    end
  end

  always_ff @(posedge clk or posedge exec) begin
    if (exec) begin
      grant <= '0;
      ack_q <= '0;
    end else if (grant == '0) begin
      grant <= pick;              // arbitrate
    end else if (ack_q == '0) begin
      ack_q <= grant;             // access done this edge
    end else if (!sel_req) begin
      ack_q <= '0;                // phase 4, free again next cycle
      grant <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (sel_we) ram[sel_addr] <= sel_wdata;
      rdata_q <= ram[sel_addr];   // old contents on a write
    end
  end

  assign host_rdata  = rdata_q;
  assign fetch_rdata = rdata_q;
  assign mem_rdata   = rdata_q;
  assign host_ack    = ack_q[host_i];
  assign mem_ack     = ack_q[mem_i];
  assign fetch_ack   = ack_q[fetch_i];

  // one requester served at a time across host, fetch and execute
  a_one_ack: assert property (@(posedge clk) disable iff (exec)
    $onehot0({host_ack, mem_ack, fetch_ack}));

endmodule

//--- src/fetch_stage.sv
`include "cpu_config.svh"

module fetch_stage (
  input  logic           clk,
  input  logic           exec,
  input  logic           run,
  output logic           fetch_req,
  output cpu_pkg::addr_t fetch_addr,
  input  cpu_pkg::word_t fetch_rdata,
  input  logic           fetch_ack,
  output logic           instr_req,
  output cpu_pkg::addr_t instr_pc,
  output cpu_pkg::word_t instr_word1,
  output cpu_pkg::word_t instr_word2,
  input  logic           instr_ack,
  input  logic           jump_taken,
  input  cpu_pkg::addr_t jump_target
);
  import cpu_pkg::*;

  fetch_state_t state;
  addr_t        pc;          // next word to read
  addr_t        buf_pc;      // prefetch buffer
  word_t        buf_word1;
  word_t        buf_word2;
  logic         stale;       // read in flight belongs to a flushed path
  logic         redirect;    // jump acked this cycle
  logic         slot_free;
  logic         mem_idle;
  logic         mem_done;
  logic         issue_read;
  logic         load_slot;

  assign redirect   = instr_req && instr_ack && jump_taken;
  assign slot_free  = !instr_req && !instr_ack;  // previous handshake fully closed
  assign mem_idle   = !fetch_req && !fetch_ack;
  assign mem_done   = fetch_req && fetch_ack;
  assign issue_read = (state == read_first || state == read_second) && mem_idle && !redirect;
  assign load_slot  = (state == offer) && slot_free;

  always_ff @(posedge clk or posedge exec) begin
    if (exec) begin
      state     <= idle;
      pc        <= addr_t'(`CPU_PROG_START);
      fetch_req <= 1'b0;
      instr_req <= 1'b0;
      stale     <= 1'b0;
    end else begin
      if (instr_req && instr_ack) instr_req <= 1'b0;  // phase 3
      if (mem_done) fetch_req <= 1'b0;
      if (issue_read) fetch_req <= 1'b1;
      case (state)
        idle: if (run) state <= read_first;
        read_first, read_second: begin
          if (mem_done) begin
            if (stale || redirect) begin
              state <= read_first;  // drop the word as pc already points at the target
              stale <= 1'b0;
            end else begin
              pc    <= pc + 1'b1;
              state <= (state == read_first) ? read_second : offer;
            end
          end
          if (redirect) begin
            pc    <= jump_target;
            state <= read_first;
            stale <= fetch_req && !fetch_ack;  // still waiting on memory
          end
        end
        offer: begin
          if (redirect) begin
            pc    <= jump_target;  // flush buffer
            state <= read_first;
          end else if (load_slot) begin
            instr_req <= 1'b1;
            // nothing after a halt gets executed
            state <= (opcode_t'(buf_word1[15:8]) == op_halt) ? halted : read_first;
          end
        end
        halted: state <= halted;  // until reset
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue_read) fetch_addr <= pc;  // held while req is up
    if (mem_done && state == read_first) begin
      buf_word1 <= fetch_rdata;
      buf_pc    <= fetch_addr;
    end
    if (mem_done && state == read_second) buf_word2 <= fetch_rdata;
    if (load_slot) begin
      instr_pc    <= buf_pc;
      instr_word1 <= buf_word1;
      instr_word2 <= buf_word2;
    end
  end

  // execute answers only while the offer is still up
  a_ack_needs_req: assert property (@(posedge clk) disable iff (exec)
    $rose(instr_ack) |-> instr_req);

  // a jump is reported only together with its ack
  a_jump_with_ack: assert property (@(posedge clk) disable iff (exec)
    jump_taken |-> instr_ack);

endmodule

//--- src/exec_stage.sv
`include "cpu_config.svh"

module exec_stage (
  input  logic             clk,
  input  logic             exec,
  input  logic             instr_req,
  input  cpu_pkg::word_t   instr_word1,
  input  cpu_pkg::word_t   instr_word2,
  output logic             instr_ack,
  output logic             jump_taken,
  output cpu_pkg::addr_t   jump_target,
  output logic             mem_req,
  output logic             mem_we,
  output cpu_pkg::addr_t   mem_addr,
  output cpu_pkg::word_t   mem_wdata,
  input  cpu_pkg::word_t   mem_rdata,
  input  logic             mem_ack,
  output logic             trace_push,
  output cpu_pkg::opcode_t trace_byte,
  input  logic             trace_full
  ,
  output logic             halted
);
  import cpu_pkg::*;

  exec_state_t state;
  word_t       regs [`CPU_REG_COUNT];
  opcode_t     opcode;
  reg_idx_t    rd;
  logic        start;     // new instruction accepted
  logic        accepted;  // trace byte taken by the fifo

  // fetch holds both words until we ack, no local copy needed
  assign opcode     = opcode_t'(instr_word1[15:8]);
  assign rd         = instr_word1[$bits(reg_idx_t)-1:0];
  assign start      = (state == wait_instr) && instr_req && !instr_ack;
  assign trace_byte = opcode;                   // unknown opcodes traced as is
  assign trace_push = (state == push_trace);
  assign accepted   = trace_push && !trace_full;

  always_ff @(posedge clk or posedge exec) begin
    if (exec) begin
      state      <= wait_instr;
      instr_ack  <= 1'b0;
      jump_taken <= 1'b0;
      mem_req    <= 1'b0;
      mem_we     <= 1'b0;
      halted     <= 1'b0;
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      case (state)
        wait_instr: begin
          if (instr_ack && !instr_req) begin
            instr_ack  <= 1'b0;  // phase 4
            jump_taken <= 1'b0;
          end else if (start) begin
            case (opcode)
              op_ram2reg, op_reg2ram: begin
                mem_req <= 1'b1;
                mem_we  <= (opcode == op_reg2ram);
                state   <= mem_access;
              end
              op_num2reg: begin
                regs[rd] <= instr_word2;
                state    <= push_trace;
              end
              default: state <= push_trace;  // jmp, halt, no-ops
            endcase
          end
        end
        mem_access: begin
          if (mem_req && mem_ack) begin
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
            if (!mem_we) regs[rd] <= mem_rdata;  // load result
          end else if (!mem_req && !mem_ack) begin
            state <= push_trace;  // ram has closed the handshake
          end
        end
        push_trace: begin
          // full fifo stalls here, so fetch sees no ack
          if (accepted) begin
            instr_ack  <= 1'b1;
            jump_taken <= (opcode == op_jmp);
            state      <= (opcode == op_halt) ? done : wait_instr;
          end
        end
        done: begin
          halted <= 1'b1;  // one cycle after the halt ack
          if (instr_ack && !instr_req) instr_ack <= 1'b0;
        end
        default: state <= wait_instr;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      mem_addr  <= addr_t'(instr_word2);  // low byte addresses the ram
      mem_wdata <= regs[rd];
    end
    if (accepted) jump_target <= addr_t'(instr_word2);
  end

endmodule

//--- src/uart_trace.sv
`include "cpu_config.svh"

module uart_trace (
  input  logic             clk,
  input  logic             exec,
  input  logic             trace_push,
  input  cpu_pkg::opcode_t trace_byte,
  output logic             trace_full,
  output logic             tx
);
  import cpu_pkg::*;

  localparam int depth = `CPU_TRACE_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);
  localparam int tick_w = (`CPU_CLKS_PER_BIT > 1) ? $clog2(`CPU_CLKS_PER_BIT) : 1;

  opcode_t           fifo [depth];
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cnt_w-1:0]  count;
  logic              do_push;
  logic              do_pop;
  logic              busy;       // a frame is on the line
  logic [8:0]        shifter;    // data lsb first, then stop bit
  logic [3:0]        bits_left;  // bits still to send after the current one
  logic [tick_w-1:0] tick;       // clocks left in the current bit
  logic              bit_end;
  logic              shift_out;

  assign trace_full = (count == cnt_w'(depth));
  assign do_push    = trace_push && !trace_full;
  assign do_pop     = !busy && (count != '0);
  assign bit_end    = busy && (tick == '0);
  assign shift_out  = bit_end && (bits_left != '0);

  always_ff @(posedge clk) begin
    if (do_push) fifo[wr_ptr] <= trace_byte;
  end

  always_ff @(posedge clk or posedge exec) begin
    if (exec) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      busy      <= 1'b0;
      tx        <= 1'b1;  // idle line is high
      bits_left <= '0;
      tick      <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      if (do_pop) begin
        busy      <= 1'b1;
        tx        <= 1'b0;   // start bit
        bits_left <= 4'd9;   // 8 data + stop
        tick      <= tick_w'(`CPU_CLKS_PER_BIT - 1);
      end else if (shift_out) begin
        tx        <= shifter[0];
        bits_left <= bits_left - 1'b1;
        tick      <= tick_w'(`CPU_CLKS_PER_BIT - 1);
      end else if (bit_end) begin
        busy <= 1'b0;        // stop bit done, line stays high
      end else if (busy) begin
        tick <= tick - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_pop) shifter <= {1'b1, fifo[rd_ptr]};
    else if (shift_out) shifter <= {1'b1, shifter[8:1]};
  end

  // a byte refused while full stays offered until taken
  a_hold_when_full: assert property (@(posedge clk) disable iff (exec)
    trace_push && trace_full |=> trace_push && $stable(trace_byte));

endmodule

//--- src/cpu_top.sv
module cpu_top (
  input  logic           clk,
  input  logic           exec,
  input  logic           run,
  input  logic           host_req,
  input  logic           host_we,
  input  cpu_pkg::addr_t host_addr,
  input  cpu_pkg::word_t host_wdata,
  output cpu_pkg::word_t host_rdata,
  output logic           host_ack,
  output logic           halted,
  output logic           tx
);
  import cpu_pkg::*;

  // fetch <-> ram
  logic    fetch_req;
  logic    fetch_ack;
  addr_t   fetch_addr;
  word_t   fetch_rdata;
  // execute <-> ram
  logic    mem_req;
  logic    mem_we;
  logic    mem_ack;
  addr_t   mem_addr;
  word_t   mem_wdata;
  word_t   mem_rdata;
  // fetch -> execute
  logic    instr_req;
  logic    instr_ack;
  logic    jump_taken;
  addr_t   jump_target;
  word_t   instr_word1;
  word_t   instr_word2;
  // execute -> trace
  logic    trace_push;
  logic    trace_full;
  opcode_t trace_byte;

  shared_ram u_ram (
    .clk         (clk),
    .exec        (exec),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata),
    .host_ack    (host_ack),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_rdata (fetch_rdata),
    .fetch_ack   (fetch_ack),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .mem_ack     (mem_ack)
  );

  fetch_stage u_fetch (
    .clk         (clk),
    .exec        (exec),
    .run         (run),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .fetch_rdata (fetch_rdata),
    .fetch_ack   (fetch_ack),
    .instr_req   (instr_req),
    .instr_pc    (),
    .instr_word1 (instr_word1),
    .instr_word2 (instr_word2),
    .instr_ack   (instr_ack),
    .jump_taken  (jump_taken),
    .jump_target (jump_target)
  );

  exec_stage u_exec (
    .clk         (clk),
    .exec        (exec),
    .instr_req   (instr_req),
    .instr_word1 (instr_word1),
    .instr_word2 (instr_word2),
    .instr_ack   (instr_ack),
    .jump_taken  (jump_taken),
    .jump_target (jump_target),
    .mem_req     (mem_req),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .mem_ack     (mem_ack),
    .trace_push  (trace_push),
    .trace_byte  (trace_byte),
    .trace_full  (trace_full),
    .halted      (halted)
  );

  uart_trace u_trace (
    .clk        (clk),
    .exec       (exec),
    .trace_push (trace_push),
    .trace_byte (trace_byte),
    .trace_full (trace_full),
    .tx         (tx)
  );

endmodule

//--- tb/cpu_tb.sv
`include "cpu_config.svh"

module cpu_tb;
  import cpu_pkg::*;

  localparam int n_instr    = 20;
  localparam int n_rw       = 12;                  // random host write/read pairs
  localparam int data_words = `CPU_PROG_START;     // data area 0..63
  localparam int bit_clks   = `CPU_CLKS_PER_BIT;
  localparam int host_xfers = 2 * n_rw + data_words + 2 * n_instr + data_words;
  // per instruction 40 clocks plus one frame, host traffic at 8 clocks each, doubled
  localparam int timeout_cycles =
    2 * (n_instr * (40 + 10 * bit_clks) + host_xfers * 8 + 5 + 20 * bit_clks);

  logic  clk = 1'b0;
  logic  exec;
  logic  run;
  logic  host_req;
  logic  host_we;
  addr_t host_addr;
  word_t host_wdata;
  word_t host_rdata;
  logic  host_ack;
  logic  halted;
  logic  tx;

  int         errors = 0;
  word_t      prog_w1 [n_instr];
  word_t      prog_w2 [n_instr];
  word_t      model_mem [data_words];        // expected data area
  word_t      model_regs [`CPU_REG_COUNT];
  logic [7:0] exp_trace [$];                 // executed opcodes, in order
  logic [7:0] rx_bytes [$];                  // bytes off the serial line
  logic       halt_queued = 1'b0;
  logic       prev_halted = 1'b0;

  cpu_top dut (
    .clk        (clk),
    .exec       (exec),
    .run        (run),
    .host_req   (host_req),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .host_ack   (host_ack),
    .halted     (halted),
    .tx         (tx)
  );

  always #50 clk = ~clk;

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    errors++;
    $display("** Error %s: expected %h, actual %h", name, exp, act);
  endtask

  task automatic report_fail(input string msg);
    errors++;
    $display("** Error %s", msg);
  endtask

  // one four-phase transfer on the host port
  task automatic host_access(input logic we, input addr_t a, input word_t d,
                             output word_t q);
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = a;
    host_wdata = d;
    @(negedge clk);
    while (!host_ack) @(negedge clk);
    q        = host_rdata;   // valid with ack
    host_req = 1'b0;
    @(negedge clk);
    while (host_ack) @(negedge clk);
  endtask

  task automatic build_program();
    int       r;
    int       j;
    int       hi;
    opcode_t  op;
    reg_idx_t rd;
    for (int i = 0; i < n_instr; i++) begin
      r  = $urandom_range(0, 9);
      rd = reg_idx_t'($urandom_range(0, `CPU_REG_COUNT - 1));
      if (i == n_instr - 1) op = op_halt;
      else if (i == 6) op = op_jmp;          // fixed hop over 7 and 8
      else if (i == 7) op = op_reg2ram;      // a store that must not happen
      else if (r < 3) op = op_num2reg;
      else if (r < 6) op = op_ram2reg;
      else if (r < 9 || i < 10) op = op_reg2ram;
      else op = op_jmp;                      // random jumps only after the fixed one
      prog_w1[i] = {op, 4'h0, rd};
      case (op)
        op_jmp: begin
          hi = (i + 3 < n_instr - 1) ? i + 3 : n_instr - 1;
          j  = (i == 6) ? 9 : $urandom_range(i + 1, hi);  // forward only
          prog_w1[i] = {op, 8'h00};
          prog_w2[i] = word_t'(`CPU_PROG_START + 2 * j);
        end
        op_num2reg: prog_w2[i] = word_t'($urandom);
        op_halt: begin
          prog_w1[i] = {op, 8'h00};
          prog_w2[i] = '0;
        end
        default: prog_w2[i] = word_t'($urandom_range(0, data_words - 1));
      endcase
    end
  endtask

  // plain interpreter of the same program
  task automatic run_model();
    int       i;
    opcode_t  op;
    reg_idx_t rd;
    word_t    w2;
    for (int k = 0; k < `CPU_REG_COUNT; k++) model_regs[k] = '0;
    i = 0;
    while (i < n_instr) begin
      op = opcode_t'(prog_w1[i][15:8]);
      rd = prog_w1[i][3:0];
      w2 = prog_w2[i];
      exp_trace.push_back(prog_w1[i][15:8]);
      i++;
      case (op)
        op_num2reg: model_regs[rd] = w2;
        op_ram2reg: model_regs[rd] = model_mem[w2[5:0]];
        op_reg2ram: model_mem[w2[5:0]] = model_regs[rd];
        op_jmp:     i = (int'(w2) - `CPU_PROG_START) / 2;
        op_halt:    i = n_instr;   // stop here
        default: ;
      endcase
    end
  endtask

  // 8N1 receiver, sampled near mid-bit
  initial begin : serial_rx
    logic [7:0] b;
    @(negedge exec);
    forever begin
      @(negedge clk);
      if (tx == 1'b0) begin
        repeat (bit_clks / 2) @(negedge clk);
        if (tx !== 1'b0) report_fail("start bit not low at mid-bit");
        for (int k = 0; k < 8; k++) begin
          repeat (bit_clks) @(negedge clk);
          b[k] = tx;   // lsb first
        end
        repeat (bit_clks) @(negedge clk);
        if (tx !== 1'b1) report_fail("stop bit not high at mid-bit");
        rx_bytes.push_back(b);
      end
    end
  end

  // halt ordering against the trace fifo
  always @(negedge clk) begin
    if (!exec) begin
      if (dut.trace_push && !dut.trace_full && dut.trace_byte == op_halt)
        halt_queued = 1'b1;   // taken at the next rising edge
      if (halted && !prev_halted && !halt_queued)
        report_fail("halted rose before the halt trace byte was queued");
      if (!halted && prev_halted)
        report_fail("halted fell after it was raised");
      prev_halted = halted;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("** Error run did not finish within %0d cycles", timeout_cycles);
    $display("Test failed");
    $finish;
  end

  initial begin : main_seq
    word_t q;
    word_t d;
    addr_t a;
    void'($urandom(32'h11a9_5e34));
    exec       = 1'b1;
    run        = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (5) @(negedge clk);
    exec = 1'b0;
    if (halted !== 1'b0) report_fail("halted not low after reset");
    if (tx !== 1'b1) report_fail("tx not high after reset");

    // host port round trip
    for (int n = 0; n < n_rw; n++) begin
      a = addr_t'($urandom);
      d = word_t'($urandom);
      host_access(1'b1, a, d, q);
      host_access(1'b0, a, '0, q);
      if (q !== d) report_mismatch($sformatf("host_rw @%h", a), d, q);
    end

    // data area, then the program
    for (int n = 0; n < data_words; n++) begin
      model_mem[n] = word_t'($urandom);
      host_access(1'b1, addr_t'(n), model_mem[n], q);
    end
    build_program();
    for (int n = 0; n < n_instr; n++) begin
      host_access(1'b1, addr_t'(`CPU_PROG_START + 2 * n), prog_w1[n], q);
      host_access(1'b1, addr_t'(`CPU_PROG_START + 2 * n + 1), prog_w2[n], q);
    end
    run_model();

    @(negedge clk);
    run = 1'b1;
    while (!halted) @(negedge clk);
    while (rx_bytes.size() < exp_trace.size()) @(negedge clk);
    repeat (20 * bit_clks) @(negedge clk);   // room for a stray extra frame

    if (rx_bytes.size() != exp_trace.size())
      report_mismatch("trace_count", word_t'(exp_trace.size()), word_t'(rx_bytes.size()));
    for (int n = 0; n < exp_trace.size() && n < rx_bytes.size(); n++) begin
      if (rx_bytes[n] !== exp_trace[n])
        report_mismatch($sformatf("trace[%0d]", n), word_t'(exp_trace[n]),
                        word_t'(rx_bytes[n]));
    end

    // memory after halt, skipped stores included
    for (int n = 0; n < data_words; n++) begin
      host_access(1'b0, addr_t'(n), '0, q);
      if (q !== model_mem[n]) report_mismatch($sformatf("mem[%0d]", n), model_mem[n], q);
    end
    if (halted !== 1'b1) report_fail("halted low at the end of the run");

    $display("cpu_tb done, %0d error(s)", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+src
src/cpu_pkg.sv
src/shared_ram.sv
src/fetch_stage.sv
src/exec_stage.sv
src/uart_trace.sv
src/cpu_top.sv
tb/cpu_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build cpu_tb with verilator, run it, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   this list"

test:
	verilator --binary --assert -Wno-fatal --top-module cpu_tb -f tb.f -o Vcpu_tb
	./obj_dir/Vcpu_tb | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
